// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tlul_mem_tb
FILELIST  ?= tlul_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG  := TESTBENCH FAILED
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no verdict found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

  localparam int MEM_DEPTH  = 256;         // words
  localparam int MEM_IW     = 8;           // word index width
  localparam int MEM_AW     = MEM_IW + 2;  // byte address span, 1 KB
  localparam int FIFO_DEPTH = 4;

  // request as it travels from intake to responder
  typedef struct packed {
    logic                        write;
    logic                        partial;
    tlul_pkg::tl_a_op_e          opcode;
    logic [tlul_pkg::TL_SZW-1:0] size;
    logic [tlul_pkg::TL_AIW-1:0] source;
    logic [MEM_IW-1:0]           index;
    logic [tlul_pkg::TL_DBW-1:0] mask;
    logic [tlul_pkg::TL_DW-1:0]  wdata;
    logic                        err;
  } mem_req_t;

  typedef struct packed {
    tlul_pkg::tl_d_op_e          opcode;
    logic [tlul_pkg::TL_SZW-1:0] size;
    logic [tlul_pkg::TL_AIW-1:0] source;
    logic [tlul_pkg::TL_DW-1:0]  data;
    logic                        err;
  } mem_rsp_t;

endpackage

// ==== rtl/mem_responder.sv ====
`timescale 1ns/1ps

module mem_responder (
  input  logic              clk_i,
  input  logic              rst_i,
  input  mem_pkg::mem_req_t req_i,
  input  logic              req_empty_i,
  output logic              req_pop_o,
  input  logic              rsp_full_i,
  output logic              rsp_push_o,
  output mem_pkg::mem_rsp_t rsp_o
);

  logic [tlul_pkg::TL_DW-1:0] mem_q [mem_pkg::MEM_DEPTH];

  logic stage_vld_q;  // rsp_o holds a response not yet pushed
  logic do_write;

  // stage drains into the response fifo whenever there is room
  assign rsp_push_o = stage_vld_q & ~rsp_full_i;

  // take the next request if the stage is free or frees up this edge
  assign req_pop_o = ~req_empty_i & (~stage_vld_q | rsp_push_o);

  assign do_write = req_pop_o & req_i.write & ~req_i.err;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stage_vld_q <= 1'b0;
    end else if (req_pop_o) begin
      stage_vld_q <= 1'b1;
    end else if (rsp_push_o) begin
      stage_vld_q <= 1'b0;
    end
  end

  // byte-masked write, same path for full and partial puts
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      for (int b = 0; b < tlul_pkg::TL_DBW; b++) begin
        if (req_i.mask[b]) begin
          mem_q[req_i.index][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // response stage payload
  always_ff @(posedge clk_i) begin
    if (req_pop_o) begin
      rsp_o.opcode <= (req_i.opcode == tlul_pkg::Get) ? tlul_pkg::AccessAckData
                                                      : tlul_pkg::AccessAck;
      rsp_o.size   <= req_i.size;
      rsp_o.source <= req_i.source;
      rsp_o.err    <= req_i.err;

      // only a legal get returns data
      if (req_i.err || req_i.write || req_i.opcode != tlul_pkg::Get) begin
        rsp_o.data <= '0;
      end else begin
        rsp_o.data <= mem_q[req_i.index];
      end
    end
  end

endmodule

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = mem_pkg::FIFO_DEPTH
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T mem_q [DEPTH];

  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          do_push;
  logic          do_pop;

  assign full_o  = (count_q == CW'(DEPTH));
  assign empty_o = (count_q == '0);

  // requests against a full or empty buffer are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign data_o = mem_q[rd_ptr_q];  // registered head, no fall-through

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== rtl/tlul_err.sv ====
`timescale 1ns/1ps

module tlul_err (
  input  tlul_pkg::tl_h2d_t tl_i,
  output logic              err_o
);

  logic op_get;
  logic op_full;
  logic op_partial;
  logic opcode_ok;
  logic cfg_ok;
  logic align_ok;   // address fits the size
  logic lane_ok;    // no mask bits on inactive lanes
  logic full_ok;    // mask covers the whole transfer, PutFullData only

  logic [tlul_pkg::TL_DBW-1:0] lane_sel;

  assign op_get     = (tl_i.a_opcode == tlul_pkg::Get);
  assign op_full    = (tl_i.a_opcode == tlul_pkg::PutFullData);
  assign op_partial = (tl_i.a_opcode == tlul_pkg::PutPartialData);
  assign opcode_ok  = op_get | op_full | op_partial;

  // one-hot lane for byte accesses
  assign lane_sel = tlul_pkg::TL_DBW'(1) << tl_i.a_address[1:0];

  always_comb begin
    align_ok = 1'b0;
    lane_ok  = 1'b0;
    full_ok  = 1'b0;

    if (tl_i.a_valid) begin
      case (tl_i.a_size)
        2'd0: begin // byte
          align_ok = 1'b1;
          lane_ok  = ~|(tl_i.a_mask & ~lane_sel);
          full_ok  = |(tl_i.a_mask & lane_sel);
        end

        2'd1: begin // half word
          align_ok = ~tl_i.a_address[0];
          // upper half addressed means the lower mask bits must be clear
          lane_ok  = tl_i.a_address[1] ? ~|tl_i.a_mask[1:0]
                                       : ~|tl_i.a_mask[3:2];
          full_ok  = tl_i.a_address[1] ? &tl_i.a_mask[3:2]
                                       : &tl_i.a_mask[1:0];
        end

        2'd2: begin // full word
          align_ok = (tl_i.a_address[1:0] == 2'b00);
          lane_ok  = 1'b1;
          full_ok  = &tl_i.a_mask;
        end

        default: begin // size 3, wider than the bus
          align_ok = 1'b0;
          lane_ok  = 1'b0;
          full_ok  = 1'b0;
        end
      endcase
    end
  end

  assign cfg_ok = align_ok & lane_ok & (op_get | op_partial | full_ok);

  // anything outside the permitted set is an error
  assign err_o = ~(opcode_ok & cfg_ok);

endmodule

// ==== rtl/tlul_mem_top.sv ====
`timescale 1ns/1ps

module tlul_mem_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  tlul_pkg::tl_h2d_t tl_i,
  output tlul_pkg::tl_d2h_t tl_o
);

  mem_pkg::mem_req_t req_in;
  mem_pkg::mem_req_t req_head;
  mem_pkg::mem_rsp_t rsp_in;
  mem_pkg::mem_rsp_t rsp_head;

  logic req_push;
  logic req_pop;
  logic req_full;
  logic req_empty;
  logic rsp_push;
  logic rsp_pop;
  logic rsp_full;
  logic rsp_empty;
  logic a_ready;

  tlul_req_intake u_intake (
    .tl_i      (tl_i),
    .full_i    (req_full),
    .push_o    (req_push),
    .req_o     (req_in),
    .a_ready_o (a_ready)
  );

  sync_fifo #(
    .T     (mem_pkg::mem_req_t),
    .DEPTH (mem_pkg::FIFO_DEPTH)
  ) req_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (req_push),
    .data_i  (req_in),
    .pop_i   (req_pop),
    .data_o  (req_head),
    .full_o  (req_full),
    .empty_o (req_empty)
  );

  mem_responder u_resp (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_head),
    .req_empty_i (req_empty),
    .req_pop_o   (req_pop),
    .rsp_full_i  (rsp_full),
    .rsp_push_o  (rsp_push),
    .rsp_o       (rsp_in)
  );

  sync_fifo #(
    .T     (mem_pkg::mem_rsp_t),
    .DEPTH (mem_pkg::FIFO_DEPTH)
  ) rsp_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rsp_push),
    .data_i  (rsp_in),
    .pop_i   (rsp_pop),
    .data_o  (rsp_head),
    .full_o  (rsp_full),
    .empty_o (rsp_empty)
  );

  assign rsp_pop = tl_i.d_ready & ~rsp_empty;  // d beat taken

  // d channel shows the response fifo head
  always_comb begin
    tl_o.d_valid  = ~rsp_empty;
    tl_o.d_opcode = rsp_head.opcode;
    tl_o.d_size   = rsp_head.size;
    tl_o.d_source = rsp_head.source;
    tl_o.d_data   = rsp_head.data;
    tl_o.d_error  = rsp_head.err;
    tl_o.a_ready  = a_ready;
  end

endmodule

// ==== rtl/tlul_pkg.sv ====
package tlul_pkg;

  // bus widths
  localparam int TL_AW  = 32;  // address
  localparam int TL_DW  = 32;  // data
  localparam int TL_DBW = 4;   // byte mask, one bit per lane
  localparam int TL_SZW = 2;   // log2 of the transfer size
  localparam int TL_AIW = 8;   // source id

  // a channel opcodes
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // d channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // host to device
  typedef struct packed {
    logic              a_valid;
    tl_a_op_e          a_opcode;
    logic [TL_SZW-1:0] a_size;
    logic [TL_AW-1:0]  a_address;
    logic [TL_AIW-1:0] a_source;
    logic [TL_DBW-1:0] a_mask;
    logic [TL_DW-1:0]  a_data;
    logic              d_ready;
  } tl_h2d_t;

  // device to host
  typedef struct packed {
    logic              d_valid;
    tl_d_op_e          d_opcode;
    logic [TL_SZW-1:0] d_size;
    logic [TL_AIW-1:0] d_source;
    logic [TL_DW-1:0]  d_data;
    logic              d_error;
    logic              a_ready;
  } tl_d2h_t;

endpackage

// ==== rtl/tlul_req_intake.sv ====
`timescale 1ns/1ps

module tlul_req_intake (
  input  tlul_pkg::tl_h2d_t  tl_i,
  input  logic               full_i,
  output logic               push_o,
  output mem_pkg::mem_req_t  req_o,
  output logic               a_ready_o
);

  logic chk_err;
  logic out_of_range;

  tlul_err u_err (
    .tl_i  (tl_i),
    .err_o (chk_err)
  );

  // anything at or above 1 KB
  assign out_of_range = |tl_i.a_address[tlul_pkg::TL_AW-1:mem_pkg::MEM_AW];

  assign a_ready_o = ~full_i;
  assign push_o    = tl_i.a_valid & ~full_i;  // accepted beat goes straight in

  always_comb begin
    req_o.write   = (tl_i.a_opcode == tlul_pkg::PutFullData) |
                    (tl_i.a_opcode == tlul_pkg::PutPartialData);
    req_o.partial = (tl_i.a_opcode == tlul_pkg::PutPartialData);
    req_o.opcode  = tl_i.a_opcode;
    req_o.size    = tl_i.a_size;
    req_o.source  = tl_i.a_source;
    req_o.index   = tl_i.a_address[mem_pkg::MEM_AW-1:2];  // byte to word address
    req_o.mask    = tl_i.a_mask;
    req_o.wdata   = tl_i.a_data;
    req_o.err     = chk_err | out_of_range;
  end

endmodule

// ==== tb/tlul_mem_checker.sv ====
`timescale 1ns/1ps

module tlul_mem_checker (
  input  logic              clk_i,
  input  logic              rst_i,
  input  tlul_pkg::tl_h2d_t host_i,
  input  tlul_pkg::tl_d2h_t dev_i,
  output int                checks_o,
  output int                fails_o,
  output int                pending_o
);

  typedef struct packed {
    tlul_pkg::tl_d_op_e opcode;
    logic [1:0]         size;
    logic [7:0]         source;
    logic [31:0]        data;
    logic [31:0]        care;  // bytes whose value is known
    logic               err;
  } exp_t;

  logic [31:0] model [256];
  logic [3:0]  known [256];  // per byte, written at least once
  exp_t        exp_q [$];
  exp_t        fresh;
  exp_t        head;
  logic [7:0]  idx;
  logic        rst_q;

  // legality as the bus rules state it
  function automatic logic is_illegal(input tlul_pkg::tl_h2d_t a);
    logic [3:0] lanes;
    logic       is_full;
    is_full = (a.a_opcode == tlul_pkg::PutFullData);
    if (a.a_opcode != tlul_pkg::Get && a.a_opcode != tlul_pkg::PutFullData &&
        a.a_opcode != tlul_pkg::PutPartialData) return 1'b1;
    if (a.a_address >= 32'd1024) return 1'b1;
    case (a.a_size)
      2'd0: lanes = 4'b0001 << a.a_address[1:0];
      2'd1: begin
        if (a.a_address[0]) return 1'b1;
        lanes = a.a_address[1] ? 4'b1100 : 4'b0011;
      end
      2'd2: begin
        if (a.a_address[1:0] != 2'b00) return 1'b1;
        lanes = 4'b1111;
      end
      default: return 1'b1;
    endcase
    if ((a.a_mask & ~lanes) != 4'h0) return 1'b1;  // stray mask bits
    if (is_full && a.a_mask != lanes) return 1'b1;
    return 1'b0;
  endfunction

  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_q.delete();
      checks_o = 0;
      fails_o  = 0;
      for (int i = 0; i < 256; i++) known[i] = 4'h0;
    end else begin
      if (rst_q) begin  // first edge out of reset
        checks_o++;
        if (!dev_i.a_ready || dev_i.d_valid) begin
          fails_o++;
          $display("CHECK FAILED at %0t: after reset a_ready %b d_valid %b",
                   $time, dev_i.a_ready, dev_i.d_valid);
        end
      end
      if (dev_i.d_valid && host_i.d_ready) begin
        checks_o++;
        if (exp_q.size() == 0) begin
          fails_o++;
          $display("CHECK FAILED at %0t: response with no request outstanding", $time);
        end else begin
          head = exp_q.pop_front();
          if (dev_i.d_opcode !== head.opcode || dev_i.d_size !== head.size ||
              dev_i.d_source !== head.source || dev_i.d_error !== head.err ||
              (dev_i.d_data & head.care) !== (head.data & head.care)) begin
            fails_o++;
            // each field as got/exp
            $display("CHECK FAILED at %0t: src %h op %0d/%0d sz %0d/%0d err %b/%b data %h/%h",
                     $time, head.source, dev_i.d_opcode, head.opcode, dev_i.d_size,
                     head.size, dev_i.d_error, head.err, dev_i.d_data, head.data);
          end
        end
      end
      if (host_i.a_valid && dev_i.a_ready) begin
        idx           = host_i.a_address[9:2];
        fresh.err     = is_illegal(host_i);
        fresh.opcode  = (host_i.a_opcode == tlul_pkg::Get) ? tlul_pkg::AccessAckData
                                                           : tlul_pkg::AccessAck;
        fresh.size    = host_i.a_size;
        fresh.source  = host_i.a_source;
        fresh.data    = '0;
        fresh.care    = '1;
        if (!fresh.err && host_i.a_opcode == tlul_pkg::Get) begin
          fresh.data = model[idx];
          for (int b = 0; b < 4; b++) fresh.care[8*b +: 8] = {8{known[idx][b]}};
        end else if (!fresh.err) begin
          for (int b = 0; b < 4; b++) begin
            if (host_i.a_mask[b]) begin
              model[idx][8*b +: 8] = host_i.a_data[8*b +: 8];
              known[idx][b] = 1'b1;
            end
          end
        end
        exp_q.push_back(fresh);
      end
    end
    rst_q     = rst_i;
    pending_o = exp_q.size();
  end

endmodule

// ==== tb/tlul_mem_properties.sv ====
`timescale 1ns/1ps

module tlul_mem_properties (
  input logic              clk_i,
  input logic              rst_i,
  input tlul_pkg::tl_h2d_t host_i,
  input tlul_pkg::tl_d2h_t dev_i
);

  // stalled response must not move
  d_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    dev_i.d_valid && !host_i.d_ready |=> dev_i.d_valid && $stable(dev_i.d_opcode) &&
      $stable(dev_i.d_size) && $stable(dev_i.d_source) && $stable(dev_i.d_data) &&
      $stable(dev_i.d_error))
    else $error("d channel changed while stalled");

  reset_idle: assert property (@(posedge clk_i)
    rst_i |=> !dev_i.d_valid && dev_i.a_ready)
    else $error("d_valid or a_ready wrong after reset");

  err_data: assert property (@(posedge clk_i) disable iff (rst_i)
    dev_i.d_valid && dev_i.d_error |-> dev_i.d_data == '0)
    else $error("error response carries data");

endmodule

bind tlul_mem_top tlul_mem_properties props0 (
  .clk_i  (clk_i),
  .rst_i  (rst_i),
  .host_i (tl_i),
  .dev_i  (tl_o)
);

// ==== tb/tlul_mem_tb.sv ====
`timescale 1ns/1ps

module tlul_mem_tb;

  localparam int TIMEOUT = 200;  // cycles per wait

  logic clk = 1'b0;
  logic rst;
  logic d_rdy = 1'b1;
  logic bp_on;
  logic saw_stall = 1'b0;
  tlul_pkg::tl_h2d_t a_drv;
  tlul_pkg::tl_h2d_t host;
  tlul_pkg::tl_d2h_t dev;
  tlul_pkg::tl_a_op_e err_op;

  int seed;
  int bp_seed;
  int checks;
  int fails;
  int pending;
  int local_fails;
  int base_checks;
  int base_fails;
  logic [7:0]  pool [16];  // word indices the tests share
  logic [31:0] r;
  logic [31:0] w;
  logic [31:0] d;
  logic [31:0] bp_rnd;

  always_comb begin
    host         = a_drv;
    host.d_ready = d_rdy;
  end

  tlul_mem_top dut0 (.clk_i(clk), .rst_i(rst), .tl_i(host), .tl_o(dev));

  tlul_mem_checker chk0 (
    .clk_i     (clk),
    .rst_i     (rst),
    .host_i    (host),
    .dev_i     (dev),
    .checks_o  (checks),
    .fails_o   (fails),
    .pending_o (pending)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    #1;
    bp_rnd = $random(bp_seed);
    d_rdy  = ~bp_on | (bp_rnd[0] & bp_rnd[1]);  // about a quarter ready under back-pressure
  end

  always @(negedge clk) if (bp_on && !dev.a_ready) saw_stall = 1'b1;

  function automatic logic [31:0] word_addr(input logic [3:0] sel);
    return {22'd0, pool[sel], 2'b00};
  endfunction

  task automatic send(input tlul_pkg::tl_a_op_e op, input logic [1:0] size,
                      input logic [31:0] addr, input logic [3:0] mask, input logic [31:0] data);
    int          waited;
    logic [31:0] src;
    waited = 0;
    src    = $random(seed);
    a_drv.a_valid   = 1'b1;
    a_drv.a_opcode  = op;
    a_drv.a_size    = size;
    a_drv.a_address = addr;
    a_drv.a_source  = src[7:0];
    a_drv.a_mask    = mask;
    a_drv.a_data    = data;
    while (!dev.a_ready && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (waited >= TIMEOUT) begin
      local_fails++;
      $display("timeout at %0t: a_ready stayed low for %0d cycles", $time, TIMEOUT);
    end else begin
      @(posedge clk);  // beat accepted here
      #1;
    end
    a_drv.a_valid = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while (pending != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (pending != 0) begin
      local_fails++;
      $display("timeout: %0d responses never arrived in test %s", pending, name);
    end
    $display("test %s: %0d checks, %0d failures", name, checks - base_checks,
             fails + local_fails - base_fails);
    base_checks = checks;
    base_fails  = fails + local_fails;
  endtask

  initial begin
    rst = 1'b1;
    bp_on = 1'b0;
    a_drv = '0;
    seed = 32'h309508ed;
    bp_seed = seed ^ 32'h5a5a5a5a;
    local_fails = 0;
    base_checks = 0;
    base_fails = 0;
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      pool[i] = r[7:0];
    end
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    @(posedge clk);  // checker looks at the idle state here
    #1;
    finish_test("reset state");

    for (int i = 0; i < 16; i++) begin
      d = $random(seed);
      send(tlul_pkg::PutFullData, 2'd2, word_addr(i[3:0]), 4'hf, d);
    end
    for (int i = 0; i < 16; i++) send(tlul_pkg::Get, 2'd2, word_addr(i[3:0]), 4'hf, '0);
    finish_test("full-word traffic");

    repeat (24) begin
      r = $random(seed);
      d = $random(seed);
      w = word_addr(r[3:0]);
      case (r[5:4])
        2'd0: send(r[8] ? tlul_pkg::PutFullData : tlul_pkg::PutPartialData, 2'd0,
                   w + {30'd0, r[7:6]}, 4'b0001 << r[7:6], d);
        2'd1: send(r[8] ? tlul_pkg::PutFullData : tlul_pkg::PutPartialData, 2'd1,
                   w + {30'd0, r[6], 1'b0},
                   (r[6] ? 4'b1100 : 4'b0011) & (r[8] ? 4'hf : r[12:9]), d);
        default: send(tlul_pkg::PutPartialData, 2'd2, w, r[12:9], d);
      endcase
      send(tlul_pkg::Get, 2'd2, w, 4'hf, '0);
    end
    finish_test("partial writes");

    repeat (18) begin
      r = $random(seed);
      d = $random(seed);
      w = word_addr(r[7:4]);
      err_op = r[3] ? tlul_pkg::Get : tlul_pkg::PutFullData;  // erroneous reads too
      case (r[2:0])
        3'd0: send(tlul_pkg::tl_a_op_e'(3'h3), 2'd2, w, 4'hf, d);  // bad opcode
        3'd1: send(err_op, 2'd2, w + 32'd2, 4'hf, d);               // misaligned
        3'd2: send(err_op, 2'd0, w, 4'b0110, d);                    // stray lanes
        3'd3: send(tlul_pkg::PutFullData, 2'd1, w, 4'b0001, d);    // short full mask
        3'd4: send(err_op, 2'd3, w, 4'hf, d);
        default: send(err_op, 2'd2, w + 32'h400, 4'hf, d);
      endcase
      send(tlul_pkg::Get, 2'd2, w, 4'hf, '0);
    end
    finish_test("error cases");

    bp_on = 1'b1;
    repeat (40) begin
      r = $random(seed);
      d = $random(seed);
      w = word_addr(r[7:4]);
      case (r[1:0])
        2'd0: send(tlul_pkg::PutFullData, 2'd2, w, 4'hf, d);
        2'd1: send(tlul_pkg::PutPartialData, 2'd2, w, r[11:8], d);
        2'd2: send(tlul_pkg::Get, 2'd2, w, 4'hf, '0);
        default: send(tlul_pkg::PutFullData, 2'd1, w + 32'd1, 4'h3, d);
      endcase
    end
    if (!saw_stall) begin
      local_fails++;
      $display("a_ready never went low while responses were held back");
    end
    finish_test("back-pressure");
    bp_on = 1'b0;

    $display("total: %0d checks, %0d failures", checks, fails + local_fails);
    if (fails + local_fails == 0 && checks > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tlul_mem.f ====
rtl/tlul_pkg.sv
rtl/mem_pkg.sv
rtl/tlul_err.sv
rtl/tlul_req_intake.sv
rtl/sync_fifo.sv
rtl/mem_responder.sv
rtl/tlul_mem_top.sv
tb/tlul_mem_checker.sv
tb/tlul_mem_properties.sv
tb/tlul_mem_tb.sv
